//--- hdl/tdc_pkg.sv
`default_nettype none

package tdc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data path widths
	typedef logic [31:0] tdc_word_t; // {id, width, extra}
	typedef logic [3:0] id_t;
	typedef logic [11:0] width_t; // saturates at all ones
	typedef logic [15:0] dist_t; // all ones means no trigger yet
	typedef logic [31:0] event_cnt_t;
	typedef logic [7:0] cnt_byte_t;

	// bus side
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0] bus_byte_t;

	localparam id_t DATA_IDENTIFIER = 4'b0100;
	localparam bus_byte_t VERSION = 8'd2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output fifo
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
	typedef logic [FIFO_AW:0] fifo_cnt_t; // one extra bit to hold FIFO_DEPTH

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map
	localparam bus_addr_t REG_RESET = 16'd0;
	localparam bus_addr_t REG_VERSION = 16'd1;
	localparam bus_addr_t REG_CONFIG = 16'd2;
	localparam bus_addr_t REG_ARM = 16'd3;
	localparam bus_addr_t REG_EVENT0 = 16'd4; // lsb of event count
	localparam bus_addr_t REG_EVENT1 = 16'd5;
	localparam bus_addr_t REG_EVENT2 = 16'd6;
	localparam bus_addr_t REG_EVENT3 = 16'd7;
	localparam bus_addr_t REG_MISS = 16'd8;
	localparam bus_addr_t REG_LOST = 16'd9;

	// bits of REG_CONFIG
	localparam int CFG_EN = 0;
	localparam int CFG_ARM_MODE = 1;
	localparam int CFG_WRITE_TS = 2;
	localparam int CFG_TRIG_DIST = 3;
	localparam int CFG_INV_SIG = 4;
	localparam int CFG_INV_TRIG = 5;

endpackage

`default_nettype wire

//--- hdl/tdc_cfg_if.sv
`default_nettype none
`timescale 1ns/100ps

interface tdc_cfg_if;

	logic en; // config enable or ext_en
	logic arm_pulse; // one cycle
	logic en_arm_mode;
	logic en_write_timestamp;
	logic en_trig_distance;
	logic inv_sig;
	logic inv_trig;
	logic soft_rst; // one cycle, leaves config alone

	modport regs (
		output en, arm_pulse, en_arm_mode, en_write_timestamp,
		output en_trig_distance, inv_sig, inv_trig, soft_rst
	);

	modport core (
		input en, arm_pulse, en_arm_mode, en_write_timestamp,
		input en_trig_distance, inv_sig, inv_trig, soft_rst
	);

endinterface

`default_nettype wire

//--- hdl/tdc_bus_regs.sv
`default_nettype none
`timescale 1ns/100ps

module tdc_bus_regs (
	input wire BUS_CLK,
	input wire bus_clk_rst,

	input wire tdc_pkg::bus_addr_t bus_add,
	inout wire tdc_pkg::bus_byte_t bus_data,
	input wire bus_wr,
	input wire bus_rd,

	input wire ext_en,
	input wire arm_tdc,

	input wire tdc_pkg::event_cnt_t event_cnt,
	input wire tdc_pkg::cnt_byte_t miss_cnt,
	input wire tdc_pkg::cnt_byte_t lost_cnt,

	tdc_cfg_if.regs cfg
);

tdc_pkg::bus_byte_t config_q;
tdc_pkg::bus_byte_t rd_byte;
logic wr_reset;
logic wr_arm;
logic wr_config;
logic arm_tdc_d;
logic soft_rst_q;
logic arm_pulse_q;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write decode

assign wr_reset = bus_wr && (bus_add == tdc_pkg::REG_RESET);
assign wr_arm = bus_wr && (bus_add == tdc_pkg::REG_ARM);
assign wr_config = bus_wr && (bus_add == tdc_pkg::REG_CONFIG);

always_ff @(posedge BUS_CLK) begin
	if (bus_clk_rst)
		config_q <= '0;
	else if (wr_config)
		config_q <= bus_data;
end

// one-cycle strobes, written value does not matter
always_ff @(posedge BUS_CLK) begin
	if (bus_clk_rst) begin
		soft_rst_q <= 1'b0;
		arm_pulse_q <= 1'b0;
		arm_tdc_d <= 1'b0;
	end else begin
		soft_rst_q <= wr_reset;
		arm_pulse_q <= wr_arm || (arm_tdc && !arm_tdc_d); // bus write or ext rising edge
		arm_tdc_d <= arm_tdc;
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration to the core

assign cfg.en = config_q[tdc_pkg::CFG_EN] | ext_en;
assign cfg.en_arm_mode = config_q[tdc_pkg::CFG_ARM_MODE];
assign cfg.en_write_timestamp = config_q[tdc_pkg::CFG_WRITE_TS];
assign cfg.en_trig_distance = config_q[tdc_pkg::CFG_TRIG_DIST];
assign cfg.inv_sig = config_q[tdc_pkg::CFG_INV_SIG];
assign cfg.inv_trig = config_q[tdc_pkg::CFG_INV_TRIG];
assign cfg.soft_rst = soft_rst_q;
assign cfg.arm_pulse = arm_pulse_q;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read back

always_comb begin
	case (bus_add)
		tdc_pkg::REG_VERSION: rd_byte = tdc_pkg::VERSION;
		tdc_pkg::REG_CONFIG: rd_byte = config_q;
		tdc_pkg::REG_EVENT0: rd_byte = event_cnt[7:0];
		tdc_pkg::REG_EVENT1: rd_byte = event_cnt[15:8];
		tdc_pkg::REG_EVENT2: rd_byte = event_cnt[23:16];
		tdc_pkg::REG_EVENT3: rd_byte = event_cnt[31:24];
		tdc_pkg::REG_MISS: rd_byte = miss_cnt;
		tdc_pkg::REG_LOST: rd_byte = lost_cnt;
		default: rd_byte = '0; // reset, arm and unmapped
	endcase
end

// only drive the bus during a read cycle
assign bus_data = bus_rd ? rd_byte : 'z;

// a reset write back to back would clear the core twice
soft_rst_single_a: assert property (
	@(posedge BUS_CLK) disable iff (bus_clk_rst)
	cfg.soft_rst |=> !cfg.soft_rst
) else $error("soft reset high for two cycles");

endmodule

`default_nettype wire

//--- hdl/tdc_pulse_core.sv
`default_nettype none
`timescale 1ns/100ps

module tdc_pulse_core (
	input wire BUS_CLK,
	input wire bus_clk_rst,

	input wire tdc_in,
	input wire trig_in,
	input wire tdc_pkg::dist_t timestamp,

	tdc_cfg_if.core cfg,

	output logic word_valid,
	output tdc_pkg::tdc_word_t word,
	output tdc_pkg::event_cnt_t event_cnt,
	output tdc_pkg::cnt_byte_t miss_cnt
);

typedef enum logic [1:0] {
	ST_IDLE,
	ST_MEASURE,
	ST_EMIT
} state_t;

state_t state;
logic clr;
logic [1:0] sig_sync;
logic [1:0] trig_sync;
logic sig, sig_d;
logic trig, trig_d;
logic sig_rise, sig_fall, trig_rise;
logic armed;
logic accept; // pulse start that gets recorded
logic miss;
tdc_pkg::width_t width_cnt;
tdc_pkg::dist_t dist_cnt;
tdc_pkg::dist_t dist_q;
tdc_pkg::dist_t ts_q;
tdc_pkg::dist_t extra;

assign clr = bus_clk_rst | cfg.soft_rst;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronizers and edges

always_ff @(posedge BUS_CLK) begin
	sig_sync <= {sig_sync[0], tdc_in};
	trig_sync <= {trig_sync[0], trig_in};
	sig_d <= sig;
	trig_d <= trig;
end

assign sig = sig_sync[1] ^ cfg.inv_sig;
assign trig = trig_sync[1] ^ cfg.inv_trig;
assign sig_rise = sig && !sig_d;
assign sig_fall = !sig && sig_d;
assign trig_rise = trig && !trig_d;

assign accept = cfg.en && sig_rise && (!cfg.en_arm_mode || armed);
assign miss = cfg.en && sig_rise && cfg.en_arm_mode && !armed;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fsm, word goes out two cycles after the falling edge

always_ff @(posedge BUS_CLK) begin
	if (clr) begin
		state <= ST_IDLE;
		word_valid <= 1'b0;
	end else begin
		word_valid <= (state == ST_EMIT);
		case (state)
			ST_IDLE: if (accept) state <= ST_MEASURE;
			ST_MEASURE: begin
				if (!cfg.en)
					state <= ST_IDLE; // drop the pulse
				else if (sig_fall)
					state <= ST_EMIT;
			end
			ST_EMIT: state <= accept ? ST_MEASURE : ST_IDLE;
			default: state <= ST_IDLE;
		endcase
	end
end

// width and captures are read in ST_EMIT before a new start overwrites them
always_ff @(posedge BUS_CLK) begin
	if (accept) begin
		width_cnt <= tdc_pkg::width_t'(1);
		ts_q <= timestamp;
		dist_q <= trig_rise ? '0 : dist_cnt;
	end else if (state == ST_MEASURE && sig && width_cnt != '1) begin
		width_cnt <= width_cnt + 1'b1;
	end
end

// cycles since last trigger edge, all ones until one is seen
always_ff @(posedge BUS_CLK) begin
	if (clr || !cfg.en)
		dist_cnt <= '1;
	else if (trig_rise)
		dist_cnt <= tdc_pkg::dist_t'(1);
	else if (dist_cnt != '1)
		dist_cnt <= dist_cnt + 1'b1;
end

always_comb begin
	if (cfg.en_write_timestamp)
		extra = ts_q; // timestamp wins
	else if (cfg.en_trig_distance)
		extra = dist_q;
	else
		extra = '0;
end

always_ff @(posedge BUS_CLK) begin
	if (state == ST_EMIT)
		word <= {tdc_pkg::DATA_IDENTIFIER, width_cnt, extra};
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// arming and counters

always_ff @(posedge BUS_CLK) begin
	if (clr) begin
		armed <= 1'b0;
		event_cnt <= '0;
		miss_cnt <= '0;
	end else begin
		if (accept && cfg.en_arm_mode)
			armed <= 1'b0; // one pulse per arm
		else if (cfg.arm_pulse)
			armed <= 1'b1;
		if (state == ST_EMIT)
			event_cnt <= event_cnt + 1'b1;
		if (miss && miss_cnt != '1)
			miss_cnt <= miss_cnt + 1'b1;
	end
end

word_valid_single_a: assert property (
	@(posedge BUS_CLK) disable iff (clr)
	word_valid |=> !word_valid
) else $error("word_valid high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/tdc_word_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module tdc_word_fifo (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire soft_rst,

	input wire wr_en,
	input wire tdc_pkg::tdc_word_t wr_data,
	input wire rd_en,

	output tdc_pkg::tdc_word_t rd_data,
	output logic empty,
	output tdc_pkg::cnt_byte_t lost_cnt
);

tdc_pkg::tdc_word_t mem [tdc_pkg::FIFO_DEPTH];
tdc_pkg::fifo_ptr_t wr_ptr;
tdc_pkg::fifo_ptr_t rd_ptr;
tdc_pkg::fifo_cnt_t count;
logic full;
logic do_wr;
logic do_rd;

assign full = (count == tdc_pkg::fifo_cnt_t'(tdc_pkg::FIFO_DEPTH));
assign empty = (count == '0);
assign do_wr = wr_en && !full; // no back-pressure, extra words are dropped
assign do_rd = rd_en && !empty;

// show-ahead, head word is always on the output
assign rd_data = mem[rd_ptr];

always_ff @(posedge BUS_CLK) begin
	if (do_wr)
		mem[wr_ptr] <= wr_data;
end

always_ff @(posedge BUS_CLK) begin
	if (bus_clk_rst || soft_rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		lost_cnt <= '0;
	end else begin
		if (do_wr)
			wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
		if (do_rd)
			rd_ptr <= rd_ptr + 1'b1;
		case ({do_wr, do_rd})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
		if (wr_en && full && lost_cnt != '1)
			lost_cnt <= lost_cnt + 1'b1;
	end
end

occupancy_bound_a: assert property (
	@(posedge BUS_CLK) disable iff (bus_clk_rst)
	count <= tdc_pkg::fifo_cnt_t'(tdc_pkg::FIFO_DEPTH)
) else $error("fifo occupancy above depth");

endmodule

`default_nettype wire

//--- hdl/tdl_tdc.sv
`default_nettype none
`timescale 1ns/100ps

module tdl_tdc (
	input wire BUS_CLK,
	input wire bus_clk_rst,

	input wire tdc_pkg::bus_addr_t bus_add,
	inout wire tdc_pkg::bus_byte_t bus_data,
	input wire bus_wr,
	input wire bus_rd,

	input wire tdc_in,
	input wire trig_in,
	input wire tdc_pkg::dist_t timestamp,
	input wire arm_tdc,
	input wire ext_en,

	input wire fifo_read,
	output wire fifo_empty,
	output wire tdc_pkg::tdc_word_t fifo_data
);

tdc_pkg::event_cnt_t event_cnt;
tdc_pkg::cnt_byte_t miss_cnt;
tdc_pkg::cnt_byte_t lost_cnt;
tdc_pkg::tdc_word_t word;
logic word_valid;

// config and strobes from the register block
tdc_cfg_if cfg_if ();

tdc_bus_regs regs_i (
	.BUS_CLK(BUS_CLK),
	.bus_clk_rst(bus_clk_rst),
	.bus_add(bus_add),
	.bus_data(bus_data),
	.bus_wr(bus_wr),
	.bus_rd(bus_rd),
	.ext_en(ext_en),
	.arm_tdc(arm_tdc),
	.event_cnt(event_cnt),
	.miss_cnt(miss_cnt),
	.lost_cnt(lost_cnt),
	.cfg(cfg_if.regs)
);

tdc_pulse_core core_i (
	.BUS_CLK(BUS_CLK),
	.bus_clk_rst(bus_clk_rst),
	.tdc_in(tdc_in),
	.trig_in(trig_in),
	.timestamp(timestamp),
	.cfg(cfg_if.core),
	.word_valid(word_valid),
	.word(word),
	.event_cnt(event_cnt),
	.miss_cnt(miss_cnt)
);

tdc_word_fifo fifo_i (
	.BUS_CLK(BUS_CLK),
	.bus_clk_rst(bus_clk_rst),
	.soft_rst(cfg_if.soft_rst),
	.wr_en(word_valid),
	.wr_data(word),
	.rd_en(fifo_read),
	.rd_data(fifo_data),
	.empty(fifo_empty),
	.lost_cnt(lost_cnt)
);

endmodule

`default_nettype wire

//--- bench/tdl_tdc_tb.sv
`default_nettype none
`timescale 1ns/100ps

module tdl_tdc_tb;

localparam int N_ENTRIES = 13;
localparam int LONG_PULSE = 4100; // longer than the 12-bit width field
localparam int WORD_WAIT = 20; // pulse end to fifo output, with margin
localparam int ENTRY_MAX = LONG_PULSE + 100;
localparam int CYCLE_LIMIT = N_ENTRIES * ENTRY_MAX + 2000;
localparam logic [1:0] ARM_NONE = 2'd0;
localparam logic [1:0] ARM_BUS = 2'd1;
localparam logic [1:0] ARM_PIN = 2'd2;

typedef struct packed {
	logic [95:0] name;
	logic [7:0] cfg;
	int width;
	int lead; // -1 for no trigger
	logic [15:0] ts;
	logic [1:0] arm;
} entry_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// name, config, width, trigger lead, timestamp, arm source
entry_t entries [N_ENTRIES] = '{
	'{"width_5", 8'h01, 5, -1, 16'h0000, ARM_NONE},
	'{"width_37", 8'h01, 37, -1, 16'h0000, ARM_NONE},
	'{"width_sat", 8'h01, LONG_PULSE, -1, 16'h0000, ARM_NONE},
	'{"timestamp", 8'h05, 9, -1, 16'hbeef, ARM_NONE},
	'{"trig_dist", 8'h09, 6, 11, 16'h0000, ARM_NONE},
	'{"trig_same", 8'h09, 3, 0, 16'h0000, ARM_NONE},
	'{"no_trig", 8'h09, 4, -1, 16'h0000, ARM_NONE},
	'{"ts_over_dist", 8'h0d, 7, 3, 16'h1234, ARM_NONE},
	'{"inv_sig", 8'h11, 8, -1, 16'h0000, ARM_NONE},
	'{"inv_trig", 8'h29, 5, 7, 16'h0000, ARM_NONE},
	'{"arm_missed", 8'h03, 4, -1, 16'h0000, ARM_NONE},
	'{"arm_bus", 8'h03, 6, -1, 16'h0000, ARM_BUS},
	'{"arm_pin", 8'h0b, 5, 4, 16'h0000, ARM_PIN}
};

logic BUS_CLK = 1'b0;
logic bus_clk_rst = 1'b1;
logic [15:0] bus_add = 16'h0000;
wire [7:0] bus_data;
logic [7:0] bus_wdata = 8'h00;
logic bus_wr = 1'b0;
logic bus_rd = 1'b0;
logic tdc_in = 1'b0;
logic trig_in = 1'b0;
logic [15:0] timestamp = 16'h0000;
logic arm_tdc = 1'b0;
logic ext_en = 1'b0;
logic fifo_read = 1'b0;
wire fifo_empty;
wire [31:0] fifo_data;
int cycles = 0;

assign bus_data = bus_wr ? bus_wdata : 8'hzz; // dut drives only during reads

tdl_tdc dut_i (.*);

initial begin
	forever #5 BUS_CLK = ~BUS_CLK;
end

always @(posedge BUS_CLK) begin
	cycles <= cycles + 1;
	if (cycles >= CYCLE_LIMIT) begin
		$display("run timed out after %0d cycles", cycles);
		$display("Verification failed");
		$fatal(1, "timeout");
	end
end

task automatic tick();
	@(posedge BUS_CLK);
	#1;
endtask

task automatic check(input logic [95:0] name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act) begin
		$display("** Error: test %s expected %h actual %h", name, exp, act);
		$display("Verification failed");
		$fatal(1, "value mismatch");
	end
endtask

task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
	bus_add = addr;
	bus_wdata = data;
	bus_wr = 1'b1;
	tick();
	bus_wr = 1'b0;
endtask

task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
	bus_add = addr;
	bus_rd = 1'b1;
	#4; // middle of the read cycle
	data = bus_data;
	tick();
	bus_rd = 1'b0;
endtask

task automatic read_events(output logic [31:0] cnt);
	logic [7:0] b;
	for (int k = 0; k < 4; k++) begin
		bus_read(tdc_pkg::REG_EVENT0 + 16'(k), b);
		cnt[8*k +: 8] = b; // lsb first
	end
endtask

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] expected_word(input logic [7:0] c, input int width,
	input int lead, input logic [15:0] ts);
	logic [11:0] w;
	logic [15:0] x;
	w = (width > 4095) ? 12'hfff : width[11:0];
	if (c[tdc_pkg::CFG_WRITE_TS])
		x = ts; // timestamp wins over distance
	else if (c[tdc_pkg::CFG_TRIG_DIST])
		x = (lead < 0) ? 16'hffff : lead[15:0];
	else
		x = 16'h0000;
	return {4'b0100, w, x};
endfunction

// trigger leads the signal, both go back to idle together
task automatic drive_pulse(input int width, input int lead, input logic sig_inv,
	input logic trig_inv);
	if (lead >= 0) begin
		trig_in = ~trig_inv;
		repeat (lead) tick();
	end
	tdc_in = ~sig_inv;
	repeat (width) tick();
	tdc_in = sig_inv;
	trig_in = trig_inv;
endtask

task automatic wait_word(input logic [95:0] name);
	for (int n = 0; n < WORD_WAIT && fifo_empty; n++)
		tick();
	if (fifo_empty) begin
		$display("no word reached the fifo output in test %s", name);
		$display("Verification failed");
		$fatal(1, "missing word");
	end
endtask

task automatic pop_word(input logic [95:0] name, input logic [31:0] exp);
	wait_word(name);
	check(name, exp, fifo_data);
	fifo_read = 1'b1;
	tick();
	fifo_read = 1'b0;
endtask

task automatic expect_miss(input logic [95:0] name, input int misses);
	logic [7:0] b;
	repeat (WORD_WAIT) tick(); // no word may show up in this window
	check(name, 1, fifo_empty);
	bus_read(tdc_pkg::REG_MISS, b);
	check(name, misses, b);
endtask

initial begin
	entry_t e;
	logic [7:0] b;
	logic [31:0] ev;
	logic [31:0] rng;
	int events;
	int misses;
	int w;
	int fill_w [$];

	rng = 32'h21fc19fc;
	events = 0;
	misses = 0;
	repeat (16) @(posedge BUS_CLK);
	#1;
	bus_clk_rst = 1'b0;
	tick();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register access
	bus_read(tdc_pkg::REG_VERSION, b);
	check("version", 8'd2, b);
	bus_read(tdc_pkg::REG_CONFIG, b);
	check("config_reset", 8'h00, b);
	bus_write(tdc_pkg::REG_CONFIG, 8'h3a);
	bus_write(16'h0040, 8'hff); // unmapped, ignored
	bus_read(tdc_pkg::REG_CONFIG, b);
	check("config_rdback", 8'h3a, b);
	bus_read(16'h0040, b);
	check("unmapped", 8'h00, b);

	for (int i = 0; i < N_ENTRIES; i++) begin
		e = entries[i];
		bus_write(tdc_pkg::REG_CONFIG, 8'h00); // idle levels change while disabled
		tdc_in = e.cfg[tdc_pkg::CFG_INV_SIG];
		trig_in = e.cfg[tdc_pkg::CFG_INV_TRIG];
		timestamp = e.ts;
		repeat (4) tick();
		bus_write(tdc_pkg::REG_CONFIG, e.cfg);
		if (e.arm == ARM_BUS) begin
			bus_write(tdc_pkg::REG_ARM, 8'h00);
		end else if (e.arm == ARM_PIN) begin
			arm_tdc = 1'b1;
			tick();
			arm_tdc = 1'b0;
		end
		repeat (2) tick();
		drive_pulse(e.width, e.lead, e.cfg[tdc_pkg::CFG_INV_SIG], e.cfg[tdc_pkg::CFG_INV_TRIG]);
		if (e.cfg[tdc_pkg::CFG_ARM_MODE] && e.arm == ARM_NONE) begin
			misses++;
			expect_miss(e.name, misses);
		end else begin
			pop_word(e.name, expected_word(e.cfg, e.width, e.lead, e.ts));
			events++;
			if (e.arm != ARM_NONE) begin
				// one arm records one pulse, the next one is missed
				drive_pulse(e.width, -1, e.cfg[tdc_pkg::CFG_INV_SIG],
					e.cfg[tdc_pkg::CFG_INV_TRIG]);
				misses++;
				expect_miss(e.name, misses);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// overflow, nothing is read until all pulses are in
	bus_write(tdc_pkg::REG_CONFIG, 8'h01);
	for (int i = 0; i < tdc_pkg::FIFO_DEPTH + 3; i++) begin
		rng = xorshift(rng);
		w = 1 + int'(rng % 24);
		fill_w.push_back(w);
		drive_pulse(w, -1, 1'b0, 1'b0);
		repeat (6) tick();
	end
	events += tdc_pkg::FIFO_DEPTH + 3;
	repeat (WORD_WAIT) tick(); // pipeline drains well inside this
	read_events(ev);
	check("ovf_events", events, ev);
	bus_read(tdc_pkg::REG_LOST, b);
	check("ovf_lost", 3, b);
	for (int i = 0; i < tdc_pkg::FIFO_DEPTH; i++)
		pop_word("ovf_order", expected_word(8'h01, fill_w[i], -1, 16'h0000));
	check("ovf_drained", 1, fifo_empty);

	// soft reset with a word waiting in the fifo
	drive_pulse(5, -1, 1'b0, 1'b0);
	wait_word("soft_fill");
	bus_write(tdc_pkg::REG_RESET, 8'h00);
	tick();
	check("soft_empty", 1, fifo_empty);
	read_events(ev);
	check("soft_events", 0, ev);
	bus_read(tdc_pkg::REG_MISS, b);
	check("soft_miss", 0, b);
	bus_read(tdc_pkg::REG_LOST, b);
	check("soft_lost", 0, b);
	bus_read(tdc_pkg::REG_CONFIG, b);
	check("soft_config", 8'h01, b);

	$display("Verification passed");
	$finish;
end

endmodule

`default_nettype wire

//--- flist.f
hdl/tdc_pkg.sv
hdl/tdc_cfg_if.sv
hdl/tdc_bus_regs.sv
hdl/tdc_pulse_core.sv
hdl/tdc_word_fifo.sv
hdl/tdl_tdc.sv
bench/tdl_tdc_tb.sv

//--- Bender.yml
package:
  name: tdl_tdc

sources:
  - hdl/tdc_pkg.sv
  - hdl/tdc_cfg_if.sv
  - hdl/tdc_bus_regs.sv
  - hdl/tdc_pulse_core.sv
  - hdl/tdc_word_fifo.sv
  - hdl/tdl_tdc.sv
  - target: test
    files:
      - bench/tdl_tdc_tb.sv
